/* isp_stats.f */
+incdir+verif
rtl/isp_pkg.sv
rtl/frame_source.sv
rtl/pixel_fifo.sv
rtl/bayer_stats.sv
rtl/isp_stats_top.sv
verif/tb_isp_stats.sv

/* rtl/bayer_stats.sv */
/*
 * Bayer 2x2 channel statistics for auto white balance.
 * Pops tagged pixels, sums each channel, measures frame size, and reports
 * shifted averages with a one-cycle valid two cycles after frame end.
 */
`timescale 1ns/10ps

module bayer_stats #(
  parameter int NUM_COLS = 16, // Power of two
  parameter int NUM_ROWS = 8   // Power of two
) (
  input  logic                 pixel_clk,
  input  logic                 rst_i,
  input  isp_pkg::stream_tag_e rd_tag_i,
  input  isp_pkg::pixel_t      rd_data_i,
  input  logic                 empty_i,
  output logic                 rd_o,        // Pop strobe to FIFO
  output logic                 avg_valid_o, // New results this cycle
  output isp_pkg::pixel_t      ch0_avg_o,   // Even row, even col
  output isp_pkg::pixel_t      ch1_avg_o,   // Even row, odd col
  output isp_pkg::pixel_t      ch2_avg_o,   // Odd row, even col
  output isp_pkg::pixel_t      ch3_avg_o,   // Odd row, odd col
  output logic [15:0]          num_cols_o,
  output logic [15:0]          num_rows_o,
  output logic [31:0]          num_frames_o
);

  // Pixels per channel is NUM_COLS*NUM_ROWS/4
  localparam int SHIFT    = $clog2(NUM_COLS * NUM_ROWS / 4);
  localparam int SUM_BITS = isp_pkg::PIXEL_BITS + SHIFT;

  logic                               pop_pix, pop_end;
  logic                               in_frame;         // Frame start seen, no end yet
  logic                               row_q;            // Parity of current row
  logic                               col_q;            // Parity of next pixel's column
  logic                               cur_row, cur_col;
  logic                               fin_q;            // Finalise stage
  logic [1:0]                         ch;
  logic [15:0]                        col_cnt, row_cnt;
  logic [SUM_BITS-1:0]                sum_q [4];
  logic [isp_pkg::ACCUM_OUT_BITS-1:0] avg_w [4];

  // ******************************
  // Read side
  // ******************************

  // Two stall cycles after a frame end pop, FIFO soaks them up
  assign rd_o    = !empty_i && !fin_q && !avg_valid_o;
  assign pop_end = rd_o && (rd_tag_i == isp_pkg::TAG_FRAME_END);
  assign pop_pix = rd_o && !pop_end &&
                   (in_frame || rd_tag_i == isp_pkg::TAG_FRAME_START);

  // Position of the pixel at the FIFO head
  always_comb begin
    cur_row = row_q;
    cur_col = col_q;
    if (rd_tag_i == isp_pkg::TAG_FRAME_START) begin
      cur_row = 1'b0;
      cur_col = 1'b0;
    end else if (rd_tag_i == isp_pkg::TAG_LINE_START) begin
      cur_row = !row_q;
      cur_col = 1'b0;
    end
    ch = {cur_row, cur_col};
  end

  // Divide by power of two, just take the upper bits
  always_comb begin
    for (int i = 0; i < 4; i++)
      avg_w[i] = sum_q[i][SHIFT +: isp_pkg::ACCUM_OUT_BITS];
  end

  // ******************************
  // Accumulate and report
  // ******************************

  always_ff @(posedge pixel_clk) begin
    if (rst_i) begin
      in_frame     <= 1'b0;
      row_q        <= 1'b0;
      col_q        <= 1'b0;
      fin_q        <= 1'b0;
      col_cnt      <= '0;
      row_cnt      <= '0;
      avg_valid_o  <= 1'b0;
      ch0_avg_o    <= '0;
      ch1_avg_o    <= '0;
      ch2_avg_o    <= '0;
      ch3_avg_o    <= '0;
      num_cols_o   <= '0;
      num_rows_o   <= '0;
      num_frames_o <= '0;
      for (int i = 0; i < 4; i++)
        sum_q[i] <= '0;
    end else begin
      fin_q       <= pop_end;
      avg_valid_o <= fin_q;
      if (pop_pix) begin
        sum_q[ch] <= sum_q[ch] + SUM_BITS'(rd_data_i);
        row_q     <= cur_row;
        col_q     <= !cur_col;
        case (rd_tag_i)
          isp_pkg::TAG_FRAME_START: begin
            in_frame <= 1'b1;
            col_cnt  <= 16'd1;
            row_cnt  <= 16'd1;
          end
          isp_pkg::TAG_LINE_START: begin
            col_cnt <= 16'd1;          // New line, restart width
            row_cnt <= row_cnt + 1'b1;
          end
          default: col_cnt <= col_cnt + 1'b1;
        endcase
      end
      if (pop_end)
        in_frame <= 1'b0;
      // Publish everything together with avg_valid
      if (fin_q) begin
        ch0_avg_o    <= avg_w[0];
        ch1_avg_o    <= avg_w[1];
        ch2_avg_o    <= avg_w[2];
        ch3_avg_o    <= avg_w[3];
        num_cols_o   <= col_cnt;   // Width of last line
        num_rows_o   <= row_cnt;
        num_frames_o <= num_frames_o + 1'b1;
        for (int i = 0; i < 4; i++)
          sum_q[i] <= '0;
      end
    end
  end

  // Averages are plain shifts
  a_size_pow2: assert property (@(posedge pixel_clk)
    ((NUM_COLS & (NUM_COLS - 1)) == 0) && ((NUM_ROWS & (NUM_ROWS - 1)) == 0));

  // Source must open a frame before closing it
  a_end_after_start: assert property (@(posedge pixel_clk) disable iff (rst_i)
    pop_end |-> in_frame);

endmodule

/* rtl/frame_source.sv */
/*
 * Pixel source for the statistics path. Either forwards the camera stream or
 * generates a colour-bar frame, and pushes tagged pixels plus a frame-end marker.
 * Source select is only sampled between frames.
 */
`timescale 1ns/10ps

module frame_source #(
  parameter int NUM_COLS      = 16,
  parameter int NUM_ROWS      = 8,
  parameter int V_FRONT_PORCH = 2,
  parameter int V_SYNCH       = 2,
  parameter int V_BACK_PORCH  = 4,
  parameter int H_BLANK       = 3
) (
  input  logic                 pixel_clk,
  input  logic                 rst_i,
  input  logic                 cam_fv_i,     // Frame valid level
  input  logic                 cam_lv_i,     // Line valid level
  input  isp_pkg::pixel_t      cam_data_i,
  input  logic                 pattern_en_i, // 1 selects colour bars
  output logic                 wr_o,         // Push strobe
  output isp_pkg::stream_tag_e wr_tag_o,
  output isp_pkg::pixel_t      wr_data_o
);

  // Porches and sync are all blank lines here
  localparam int V_BLANK = V_FRONT_PORCH + V_SYNCH + V_BACK_PORCH;
  localparam int V_TOTAL = V_BLANK + NUM_ROWS;
  localparam int H_TOTAL = NUM_COLS + H_BLANK;
  localparam int HW      = $clog2(H_TOTAL);
  localparam int VW      = $clog2(V_TOTAL);
  localparam int BW      = $clog2(isp_pkg::NUM_BARS);

  logic          mode_q;              // Latched source, 1 = pattern
  logic          fv_q, lv_q;          // Camera levels, last cycle
  logic          cam_active;          // Camera frame in progress
  logic          first_q;             // Next camera pixel opens the frame
  logic          pat_run;             // Pattern frame in progress
  logic          pat_end_q;           // Last pattern pixel just went out
  logic [HW-1:0] h_cnt;
  logic [VW-1:0] v_cnt;
  logic          idle, start_cam, start_pat;
  logic          cam_take, cam_end, pat_take, pat_last;
  logic [BW-1:0] bar_idx;

  // ******************************
  // Frame control
  // ******************************

  assign idle      = !cam_active && !pat_run && !pat_end_q;
  assign start_cam = idle && !mode_q && cam_fv_i && !fv_q; // Only on a clean fv rise
  assign start_pat = idle && mode_q && pattern_en_i;       // Dropped enable ends the run
  assign cam_take  = (cam_active || start_cam) && cam_fv_i && cam_lv_i;
  assign cam_end   = cam_active && !cam_fv_i;

  assign pat_take = pat_run && (v_cnt >= VW'(V_BLANK)) && (h_cnt < HW'(NUM_COLS));
  assign pat_last = pat_take && (v_cnt == VW'(V_TOTAL - 1)) && (h_cnt == HW'(NUM_COLS - 1));

  // Column to bar, same on every row
  assign bar_idx = BW'((32'(h_cnt) * isp_pkg::NUM_BARS) / NUM_COLS);

  always_ff @(posedge pixel_clk) begin
    if (rst_i) begin
      mode_q     <= 1'b0;
      fv_q       <= 1'b0;
      lv_q       <= 1'b0;
      cam_active <= 1'b0;
      first_q    <= 1'b0;
      pat_run    <= 1'b0;
      pat_end_q  <= 1'b0;
      h_cnt      <= '0;
      v_cnt      <= '0;
    end else begin
      fv_q      <= cam_fv_i;
      lv_q      <= cam_lv_i;
      pat_end_q <= pat_last;
      // Mode is frozen from frame start to frame end marker
      if (idle && !start_cam && !start_pat)
        mode_q <= pattern_en_i;
      // Camera side
      if (start_cam) begin
        cam_active <= 1'b1;
        first_q    <= 1'b1;
      end else if (cam_end) begin
        cam_active <= 1'b0;
      end
      if (cam_take)
        first_q <= 1'b0; // Overrides the set above on same-cycle first pixel
      // Pattern raster counters
      if (start_pat) begin
        pat_run <= 1'b1;
        h_cnt   <= '0;
        v_cnt   <= '0;
      end else if (pat_run) begin
        if (pat_last)
          pat_run <= 1'b0;
        if (h_cnt == HW'(H_TOTAL - 1)) begin
          h_cnt <= '0;
          v_cnt <= v_cnt + 1'b1;
        end else begin
          h_cnt <= h_cnt + 1'b1;
        end
      end
    end
  end

  // ******************************
  // Push register
  // ******************************

  always_ff @(posedge pixel_clk) begin
    if (rst_i)
      wr_o <= 1'b0;
    else // Empty camera frame gives no marker
      wr_o <= cam_take || (cam_end && !first_q) || pat_take || pat_end_q;
  end

  always_ff @(posedge pixel_clk) begin
    if (pat_take) begin
      wr_data_o <= isp_pkg::COLORBAR_LEVELS[bar_idx];
      if (h_cnt != '0)
        wr_tag_o <= isp_pkg::TAG_PIXEL;
      else if (v_cnt == VW'(V_BLANK))
        wr_tag_o <= isp_pkg::TAG_FRAME_START;
      else
        wr_tag_o <= isp_pkg::TAG_LINE_START;
    end else if (cam_take) begin
      wr_data_o <= cam_data_i;
      if (start_cam || first_q)
        wr_tag_o <= isp_pkg::TAG_FRAME_START;
      else if (!lv_q)
        wr_tag_o <= isp_pkg::TAG_LINE_START; // lv rise
      else
        wr_tag_o <= isp_pkg::TAG_PIXEL;
    end else if (cam_end || pat_end_q) begin
      wr_tag_o  <= isp_pkg::TAG_FRAME_END;
      wr_data_o <= '0;
    end
  end

  // Pixels come only from the latched source, mode never moves under a frame
  a_push_matches_mode: assert property (@(posedge pixel_clk) disable iff (rst_i)
    (pat_take || cam_take) |-> (mode_q == pat_take));

endmodule

/* rtl/isp_pkg.sv */
/*
 * Shared pixel-path definitions for the statistics pipeline.
 * Source, FIFO, statistics block and testbench model refer to these by scoped name.
 */

package isp_pkg;

  // ******************************
  // Pixel widths
  // ******************************

  // Raw sensor sample, RAW10
  localparam int PIXEL_BITS = 10;

  // Reported channel average, same range as one pixel
  localparam int ACCUM_OUT_BITS = PIXEL_BITS;

  typedef logic [PIXEL_BITS-1:0] pixel_t;

  // ******************************
  // Stream tags
  // ******************************

  // Each FIFO entry carries one of these next to its pixel.
  // Frame end is a marker only, its pixel field is don't-care
  typedef enum logic [1:0] {
    TAG_PIXEL       = 2'd0, // Ordinary pixel
    TAG_LINE_START  = 2'd1, // First pixel of lines 1..N-1
    TAG_FRAME_START = 2'd2, // First pixel of line 0
    TAG_FRAME_END   = 2'd3  // No pixel attached
  } stream_tag_e;

  // ******************************
  // Colour bars
  // ******************************

  localparam int NUM_BARS = 8;

  // Evenly spaced grey levels, black to full scale
  localparam pixel_t COLORBAR_LEVELS [NUM_BARS] = '{
    10'd0,    // Bar 0
    10'd146,
    10'd292,
    10'd438,
    10'd584,
    10'd730,
    10'd876,
    10'd1023  // Bar 7, clipped to max code
  };

endpackage

/* rtl/isp_stats_top.sv */
/*
 * Pixel-clock image statistics path: frame source, tagged-pixel FIFO and
 * Bayer channel statistics. Frame geometry and FIFO depth are set here.
 */
`timescale 1ns/10ps

module isp_stats_top #(
  parameter int NUM_COLS      = 16,
  parameter int NUM_ROWS      = 8,
  parameter int V_FRONT_PORCH = 2,
  parameter int V_SYNCH       = 2,
  parameter int V_BACK_PORCH  = 4,
  parameter int H_BLANK       = 3,
  parameter int FIFO_DEPTH    = 8
) (
  input  logic            pixel_clk,
  input  logic            rst_i,
  input  logic            cam_fv_i,
  input  logic            cam_lv_i,
  input  isp_pkg::pixel_t cam_data_i,
  input  logic            pattern_en_i,
  output logic            avg_valid_o, // Frame interrupt
  output isp_pkg::pixel_t ch0_avg_o,
  output isp_pkg::pixel_t ch1_avg_o,
  output isp_pkg::pixel_t ch2_avg_o,
  output isp_pkg::pixel_t ch3_avg_o,
  output logic [15:0]     num_cols_o,
  output logic [15:0]     num_rows_o,
  output logic [31:0]     num_frames_o,
  output logic            buffer_full_err_o
);

  // Source to FIFO
  logic                 wr;
  isp_pkg::stream_tag_e wr_tag;
  isp_pkg::pixel_t      wr_data;
  // FIFO to statistics
  logic                 rd, empty;
  isp_pkg::stream_tag_e rd_tag;
  isp_pkg::pixel_t      rd_data;

  // ******************************
  // Pixel source
  // ******************************

  frame_source #(
    .NUM_COLS     (NUM_COLS     ),
    .NUM_ROWS     (NUM_ROWS     ),
    .V_FRONT_PORCH(V_FRONT_PORCH),
    .V_SYNCH      (V_SYNCH      ),
    .V_BACK_PORCH (V_BACK_PORCH ),
    .H_BLANK      (H_BLANK      )
  ) u_frame_source (
    .pixel_clk   (pixel_clk   ),
    .rst_i       (rst_i       ),
    .cam_fv_i    (cam_fv_i    ),
    .cam_lv_i    (cam_lv_i    ),
    .cam_data_i  (cam_data_i  ),
    .pattern_en_i(pattern_en_i),
    .wr_o        (wr          ),
    .wr_tag_o    (wr_tag      ),
    .wr_data_o   (wr_data     )
  );

  // Absorbs the frame-end stalls of the statistics block
  pixel_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_pixel_fifo (
    .pixel_clk        (pixel_clk        ),
    .rst_i            (rst_i            ),
    .wr_i             (wr               ),
    .wr_tag_i         (wr_tag           ),
    .wr_data_i        (wr_data          ),
    .rd_i             (rd               ),
    .rd_tag_o         (rd_tag           ),
    .rd_data_o        (rd_data          ),
    .empty_o          (empty            ),
    .buffer_full_err_o(buffer_full_err_o)
  );

  // ******************************
  // AWB statistics
  // ******************************

  bayer_stats #(.NUM_COLS(NUM_COLS), .NUM_ROWS(NUM_ROWS)) u_bayer_stats (
    .pixel_clk   (pixel_clk   ),
    .rst_i       (rst_i       ),
    .rd_tag_i    (rd_tag      ),
    .rd_data_i   (rd_data     ),
    .empty_i     (empty       ),
    .rd_o        (rd          ),
    .avg_valid_o (avg_valid_o ),
    .ch0_avg_o   (ch0_avg_o   ),
    .ch1_avg_o   (ch1_avg_o   ),
    .ch2_avg_o   (ch2_avg_o   ),
    .ch3_avg_o   (ch3_avg_o   ),
    .num_cols_o  (num_cols_o  ),
    .num_rows_o  (num_rows_o  ),
    .num_frames_o(num_frames_o)
  );

endmodule

/* rtl/pixel_fifo.sv */
/*
 * Register-array FIFO for tagged pixels between source and statistics.
 * No back-pressure to the writer; a push when full is lost and flags a sticky error.
 */
`timescale 1ns/10ps

module pixel_fifo #(
  parameter int FIFO_DEPTH = 8 // Power of two
) (
  input  logic                 pixel_clk,
  input  logic                 rst_i,
  input  logic                 wr_i,
  input  isp_pkg::stream_tag_e wr_tag_i,
  input  isp_pkg::pixel_t      wr_data_i,
  input  logic                 rd_i,             // Pop oldest entry
  output isp_pkg::stream_tag_e rd_tag_o,
  output isp_pkg::pixel_t      rd_data_o,
  output logic                 empty_o,
  output logic                 buffer_full_err_o // Sticky until reset
);

  localparam int AW = $clog2(FIFO_DEPTH);

  isp_pkg::stream_tag_e tag_mem  [FIFO_DEPTH];
  isp_pkg::pixel_t      data_mem [FIFO_DEPTH];
  logic [AW-1:0]        wr_ptr, rd_ptr;   // Wrap on their own
  logic [AW:0]          count;            // Occupancy, 0..FIFO_DEPTH
  logic                 full, push, pop;

  assign full    = (count == (AW + 1)'(FIFO_DEPTH));
  assign empty_o = (count == '0);
  assign push    = wr_i && !full;
  assign pop     = rd_i && !empty_o;

  // Head of queue, visible the cycle after its push
  assign rd_tag_o  = tag_mem[rd_ptr];
  assign rd_data_o = data_mem[rd_ptr];

  // ******************************
  // Storage
  // ******************************

  always_ff @(posedge pixel_clk) begin
    if (push) begin
      tag_mem[wr_ptr]  <= wr_tag_i;
      data_mem[wr_ptr] <= wr_data_i;
    end
  end

  // ******************************
  // Pointers and status
  // ******************************

  always_ff @(posedge pixel_clk) begin
    if (rst_i) begin
      wr_ptr            <= '0;
      rd_ptr            <= '0;
      count             <= '0;
      buffer_full_err_o <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count <= count + (AW + 1)'(push) - (AW + 1)'(pop);
      if (wr_i && full)
        buffer_full_err_o <= 1'b1; // Entry dropped
    end
  end

  // Consumer must honour empty
  a_no_pop_empty: assert property (@(posedge pixel_clk) disable iff (rst_i)
    rd_i |-> !empty_o);

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the statistics testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f isp_stats.f \
  --top-module tb_isp_stats -o sim_isp_stats

status=0
./obj_dir/sim_isp_stats > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulator exited with status $status"
  exit "$status"
fi
exit 0

/* verif/stats_model.svh */
/*
 * Reference model for the statistics testbench. Included inside the testbench
 * module and uses its NUM_COLS and NUM_ROWS. Holds one frame in raster order.
 */

`ifndef STATS_MODEL_SVH
`define STATS_MODEL_SVH

// ******************************
// Frame store
// ******************************

localparam int BAR_BITS        = $clog2(isp_pkg::NUM_BARS);
localparam int PIX_PER_CHANNEL = NUM_COLS * NUM_ROWS / 4; // One 2x2 site per channel

isp_pkg::pixel_t frame_pix [$]; // Raster order, row 0 first

function automatic void clear_frame();
  frame_pix.delete();
endfunction

function automatic void record_pixel(input isp_pkg::pixel_t pix);
  frame_pix.push_back(pix);
endfunction

// Bars run left to right, every row identical
function automatic void fill_colorbar_frame();
  int col;
  frame_pix.delete();
  for (int i = 0; i < NUM_COLS * NUM_ROWS; i++) begin
    col = i % NUM_COLS;
    frame_pix.push_back(
      isp_pkg::COLORBAR_LEVELS[BAR_BITS'(col * isp_pkg::NUM_BARS / NUM_COLS)]);
  end
endfunction

// ******************************
// Channel averages
// ******************************

// Channel is 2 x row parity + column parity
function automatic int channel_average(input int chan);
  int sum;
  int row;
  int col;
  sum = 0;
  foreach (frame_pix[i]) begin
    row = i / NUM_COLS;
    col = i % NUM_COLS;
    if ((row % 2) * 2 + (col % 2) == chan)
      sum += int'(frame_pix[i]);
  end
  return sum / PIX_PER_CHANNEL; // Truncating mean
endfunction

`endif

/* verif/tb_isp_stats.sv */
/*
 * Testbench for the image statistics path. Sends random camera frames and
 * colour-bar frames, and checks every reported frame against the model.
 */
`timescale 1ns/10ps

module tb_isp_stats;

  localparam int NUM_COLS       = 16;
  localparam int NUM_ROWS       = 8;
  localparam int TIMEOUT_CYCLES = 2000; // Several pattern frame periods
  localparam int NUM_CAM_FRAMES = 4;
  localparam int NUM_PAT_FRAMES = 3;

  logic            pixel_clk, rst_i;
  logic            cam_fv_i, cam_lv_i, pattern_en_i;
  isp_pkg::pixel_t cam_data_i;
  logic            avg_valid_o, buffer_full_err_o;
  isp_pkg::pixel_t ch0_avg_o, ch1_avg_o, ch2_avg_o, ch3_avg_o;
  logic [15:0]     num_cols_o, num_rows_o;
  logic [31:0]     num_frames_o;
  int              seed;
  int              frames_sent; // Frames expected to be reported so far
  int              exp_avg_q [$];   // Four channel averages per outstanding frame
  int              exp_frame_q [$]; // Frame number of each outstanding frame

  `include "stats_model.svh"

  isp_stats_top #(
    .NUM_COLS(NUM_COLS), .NUM_ROWS(NUM_ROWS), .V_FRONT_PORCH(2), .V_SYNCH(2),
    .V_BACK_PORCH(4), .H_BLANK(3), .FIFO_DEPTH(8)
  ) dut (
    .pixel_clk(pixel_clk), .rst_i(rst_i), .cam_fv_i(cam_fv_i), .cam_lv_i(cam_lv_i),
    .cam_data_i(cam_data_i), .pattern_en_i(pattern_en_i), .avg_valid_o(avg_valid_o),
    .ch0_avg_o(ch0_avg_o), .ch1_avg_o(ch1_avg_o), .ch2_avg_o(ch2_avg_o),
    .ch3_avg_o(ch3_avg_o), .num_cols_o(num_cols_o), .num_rows_o(num_rows_o),
    .num_frames_o(num_frames_o), .buffer_full_err_o(buffer_full_err_o)
  );

  initial begin
    pixel_clk = 1'b0;
    forever #10 pixel_clk = ~pixel_clk; // 50 MHz
  end

  // ******************************
  // Checking helpers
  // ******************************

  task automatic fail_stop();
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    assert (got == exp) else begin
      $display("error: %s got %h expected %h", name, got, exp);
      fail_stop();
    end
  endtask

  function automatic int random_gap(); // 1 to 5 idle cycles
    return 1 + int'($unsigned($random(seed)) % 32'd5);
  endfunction

  // Queue the model's averages for the frame now in the model
  task automatic expect_frame();
    for (int chan = 0; chan < 4; chan++)
      exp_avg_q.push_back(channel_average(chan));
    frames_sent++;
    exp_frame_q.push_back(frames_sent);
  endtask

  // Polled on the rising edge, the monitor updates the queue on the falling one
  task automatic wait_outstanding(input int max_left);
    int cycles;
    cycles = 0;
    while (exp_frame_q.size() > max_left) begin
      assert (cycles < TIMEOUT_CYCLES) else begin
        $display("timeout: no avg_valid_o pulse within %0d cycles", TIMEOUT_CYCLES);
        fail_stop();
      end
      cycles++;
      @(posedge pixel_clk);
    end
  endtask

  task automatic check_report(); // Against the oldest outstanding frame
    int frame_no;
    frame_no = exp_frame_q.pop_front();
    check_value("ch0_avg_o", int'(ch0_avg_o), exp_avg_q.pop_front());
    check_value("ch1_avg_o", int'(ch1_avg_o), exp_avg_q.pop_front());
    check_value("ch2_avg_o", int'(ch2_avg_o), exp_avg_q.pop_front());
    check_value("ch3_avg_o", int'(ch3_avg_o), exp_avg_q.pop_front());
    check_value("num_cols_o", int'(num_cols_o), NUM_COLS);
    check_value("num_rows_o", int'(num_rows_o), NUM_ROWS);
    check_value("num_frames_o", int'(num_frames_o), frame_no);
    $display("frame %0d checked", frame_no);
  endtask

  // Sample at the falling edge, outputs settled
  always @(negedge pixel_clk) begin
    if (!rst_i && avg_valid_o === 1'b1) begin
      assert (exp_frame_q.size() > 0) else begin
        $display("avg_valid_o pulsed with no frame outstanding");
        fail_stop();
      end
      check_report();
    end
  end

  // FIFO must never drop an entry
  always @(negedge pixel_clk) begin
    if (!rst_i) begin
      check_value("buffer_full_err_o", int'(buffer_full_err_o), 0);
    end
  end

  // ******************************
  // Camera stimulus
  // ******************************

  // Raises pattern_en_i at the start of row switch_row, -1 for never
  task automatic send_camera_frame(input int switch_row);
    isp_pkg::pixel_t pix;
    clear_frame();
    repeat (random_gap()) @(posedge pixel_clk); // fv low gap between frames
    cam_fv_i <= 1'b1;
    for (int r = 0; r < NUM_ROWS; r++) begin
      repeat (random_gap()) @(posedge pixel_clk); // lv low gap
      if (r == switch_row)
        pattern_en_i <= 1'b1;
      for (int c = 0; c < NUM_COLS; c++) begin
        pix = isp_pkg::pixel_t'($random(seed));
        cam_lv_i   <= 1'b1;
        cam_data_i <= pix;
        record_pixel(pix);
        @(posedge pixel_clk);
      end
      cam_lv_i <= 1'b0;
    end
    repeat (random_gap()) @(posedge pixel_clk);
    cam_fv_i <= 1'b0; // Frame end marker follows
    expect_frame();
  endtask

  // ******************************
  // Test sequence
  // ******************************

  initial begin
    seed         = 32'h42b9_b6b6;
    frames_sent  = 0;
    rst_i        = 1'b1;
    cam_fv_i     = 1'b0;
    cam_lv_i     = 1'b0;
    cam_data_i   = '0;
    pattern_en_i = 1'b0;
    repeat (10) @(posedge pixel_clk);
    rst_i <= 1'b0;
    @(negedge pixel_clk);
    check_value("avg_valid_o", int'(avg_valid_o), 0);
    check_value("buffer_full_err_o", int'(buffer_full_err_o), 0);
    check_value("ch0_avg_o", int'(ch0_avg_o), 0);
    check_value("ch1_avg_o", int'(ch1_avg_o), 0);
    check_value("ch2_avg_o", int'(ch2_avg_o), 0);
    check_value("ch3_avg_o", int'(ch3_avg_o), 0);
    check_value("num_cols_o", int'(num_cols_o), 0);
    check_value("num_rows_o", int'(num_rows_o), 0);
    check_value("num_frames_o", int'(num_frames_o), 0);
    // Plain passthrough frames, back to back so stalls meet new pixels
    for (int f = 0; f < NUM_CAM_FRAMES; f++)
      send_camera_frame(-1);
    // Switch mid-frame, this frame still camera
    send_camera_frame(NUM_ROWS / 2);
    fill_colorbar_frame();
    for (int f = 0; f < NUM_PAT_FRAMES; f++)
      expect_frame();
    // Last bar frame already running when the enable drops
    wait_outstanding(1);
    pattern_en_i <= 1'b0;
    wait_outstanding(0);
    // Back to the camera
    for (int f = 0; f < 2; f++)
      send_camera_frame(-1);
    wait_outstanding(0);
    repeat (20) @(posedge pixel_clk); // Any stray report fails here
    $display("sim passed");
    $finish;
  end

endmodule
